//--- regUnit_params.svh
////////////////////////////////////////////////////////////
// Shared sizes and constants for the register-operation unit
////////////////////////////////////////////////////////////
`ifndef REGUNIT_PARAMS_SVH
`define REGUNIT_PARAMS_SVH

// Register word width
`define REGUNIT_WIDTH 16

// Value loaded into the PC on reset or on a bad PC write
`define REGUNIT_RST_VEC 16'hF000

// Lowest PC value accepted by a write
`define REGUNIT_PC_MIN 16'h0200

// Operation queue entries
`define REGUNIT_FIFO_DEPTH 8

`endif

//--- cpuTypes_pkg.sv
////////////////////////////////////////////////////////////
// Datapath types and SR flag positions
////////////////////////////////////////////////////////////
`include "regUnit_params.svh"

package cpuTypes_pkg;

   // Register value
   typedef logic [`REGUNIT_WIDTH-1:0] regWord;

   // Register number, R0 to R15
   typedef logic [3:0] regIdx;

   // Source addressing mode, the As field
   typedef logic [1:0] addrMode;

   // Status bits held in the low end of R2
   localparam int flagC = 0;
   localparam int flagZ = 1;
   localparam int flagN = 2;

endpackage

//--- busTypes_pkg.sv
////////////////////////////////////////////////////////////
// Wishbone and operation word types
////////////////////////////////////////////////////////////
package busTypes_pkg;

   // Wishbone data and word address
   typedef logic [31:0] wbData;
   typedef logic [3:0]  wbAdr;

   // Operation word
   //   31:30 opcode, 29:28 As, 27:24 source, 23:20 destination
   //   15:0 immediate, the rest unused
   typedef logic [31:0] opWord;

   typedef enum logic [1:0]
   {
      opLoad = 2'd0,
      opMov  = 2'd1,
      opAdd  = 2'd2,
      opNop  = 2'd3
   } opCode;

endpackage

//--- opPort.sv
////////////////////////////////////////////////////////////
// Wishbone classic slave, operation push and register reads
////////////////////////////////////////////////////////////
module opPort
(
   input  logic                clk,
   input  logic                rst,
   input  logic                cyc,
   input  logic                stb,
   input  logic                we,
   input  busTypes_pkg::wbAdr  adr,
   input  busTypes_pkg::wbData datW,
   output busTypes_pkg::wbData datR,
   output logic                ack,
   input  logic                full,
   output logic                push,
   output busTypes_pkg::opWord pushData,
   output cpuTypes_pkg::regIdx rdSel,
   input  cpuTypes_pkg::regWord rdVal
);

   logic req;
   logic opWrite;

   // New request only while no ack is pending
   assign req = cyc && stb && !ack;
   assign opWrite = we && (adr == '0);

   // Register reads use the word address as register number
   assign rdSel = adr;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         ack  <= 1'b0;
         push <= 1'b0;
      end
      else
      begin
         // Operation writes wait here while the queue is full
         ack  <= req && (!opWrite || !full);
         push <= req && opWrite && !full;
      end
   end

   always_ff @(posedge clk)
   begin
      if (req && we)
         pushData <= datW;
      // Zero-extended register value
      if (req && !we)
         datR <= busTypes_pkg::wbData'(rdVal);
   end

endmodule

//--- opFifo.sv
////////////////////////////////////////////////////////////
// Circular queue of operation words
////////////////////////////////////////////////////////////
`include "regUnit_params.svh"

module opFifo
#(
   parameter int DEPTH = `REGUNIT_FIFO_DEPTH
)
(
   input  logic                clk,
   input  logic                rst,
   input  logic                push,
   input  logic                pop,
   input  busTypes_pkg::opWord pushData,
   output busTypes_pkg::opWord popData,
   output logic                full,
   output logic                empty
);

   localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNTW = $clog2(DEPTH + 1);

   busTypes_pkg::opWord mem [DEPTH];
   logic [PTRW-1:0] wrPtr;
   logic [PTRW-1:0] rdPtr;
   logic [CNTW-1:0] count;
   logic doPush;
   logic doPop;

   assign full   = (count == CNTW'(DEPTH));
   assign empty  = (count == '0);
   assign doPush = push && !full;
   assign doPop  = pop && !empty;

   // Head of queue
   assign popData = mem[rdPtr];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= (wrPtr == PTRW'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
         if (doPop)
            rdPtr <= (rdPtr == PTRW'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
         if (doPush && !doPop)
            count <= count + 1'b1;
         else if (doPop && !doPush)
            count <= count - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushData;
   end

endmodule

//--- opExecute.sv
////////////////////////////////////////////////////////////
// Two-cycle executor: pop and read, then compute and write
////////////////////////////////////////////////////////////
module opExecute
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 empty,
   input  busTypes_pkg::opWord  popData,
   output logic                 pop,
   output cpuTypes_pkg::regIdx  srcSel,
   output cpuTypes_pkg::regIdx  dstSel,
   output cpuTypes_pkg::addrMode mode,
   input  cpuTypes_pkg::regWord srcVal,
   input  cpuTypes_pkg::regWord dstVal,
   output logic                 wrEn,
   output logic                 flagWr,
   output cpuTypes_pkg::regWord wrData,
   output cpuTypes_pkg::regWord flags,
   output logic                 busy
);

   localparam int W = $bits(cpuTypes_pkg::regWord);

   typedef enum logic {stIdle, stWrite} stateT;

   stateT                state;
   busTypes_pkg::opCode  opReg;
   cpuTypes_pkg::regIdx  dstReg;
   cpuTypes_pkg::regWord immReg;
   cpuTypes_pkg::regWord srcReg;
   cpuTypes_pkg::regWord dstValReg;
   logic [W:0]           sum;

   // Operand selects come straight from the queue head
   assign srcSel = popData[27:24];
   assign mode   = popData[29:28];
   assign dstSel = (state == stWrite) ? dstReg : popData[23:20];

   assign pop  = (state == stIdle) && !empty;
   assign busy = (state != stIdle);

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= stIdle;
      else if (pop)
         state <= stWrite;
      else
         state <= stIdle;
   end

   // Operands captured on the pop cycle
   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         opReg     <= busTypes_pkg::opCode'(popData[31:30]);
         dstReg    <= popData[23:20];
         immReg    <= popData[15:0];
         srcReg    <= srcVal;
         dstValReg <= dstVal;
      end
   end

   assign sum = {1'b0, srcReg} + {1'b0, dstValReg};

   assign wrEn   = (state == stWrite) && (opReg != busTypes_pkg::opNop);
   assign flagWr = (state == stWrite) && (opReg == busTypes_pkg::opAdd);

   always_comb
   begin
      case (opReg)
         busTypes_pkg::opLoad: wrData = immReg;
         busTypes_pkg::opMov:  wrData = srcReg;
         default:              wrData = sum[W-1:0];
      endcase
   end

   always_comb
   begin
      flags = '0;
      flags[cpuTypes_pkg::flagC] = sum[W];
      flags[cpuTypes_pkg::flagZ] = (sum[W-1:0] == '0);
      flags[cpuTypes_pkg::flagN] = sum[W-1];
   end

endmodule

//--- regFile.sv
////////////////////////////////////////////////////////////
// Sixteen registers, constant generators and PC guard
////////////////////////////////////////////////////////////
`include "regUnit_params.svh"

module regFile
(
   input  logic                  clk,
   input  logic                  rst,
   input  cpuTypes_pkg::regIdx   srcSel,
   input  cpuTypes_pkg::regIdx   dstSel,
   input  cpuTypes_pkg::regIdx   rdSel,
   input  cpuTypes_pkg::addrMode mode,
   output cpuTypes_pkg::regWord  srcVal,
   output cpuTypes_pkg::regWord  dstVal,
   output cpuTypes_pkg::regWord  rdVal,
   output cpuTypes_pkg::regWord  pc,
   output cpuTypes_pkg::regWord  sp,
   output cpuTypes_pkg::regWord  sr,
   input  logic                  wrEn,
   input  logic                  flagWr,
   input  cpuTypes_pkg::regWord  wrData,
   input  cpuTypes_pkg::regWord  flags
);

   // R0 PC, R1 SP, R2 SR or CG1, R3 CG2
   cpuTypes_pkg::regWord regs [16];
   logic dataWr;
   logic srWr;

   // Stored value, R3 always reads zero
   function automatic cpuTypes_pkg::regWord storedVal(input cpuTypes_pkg::regIdx sel);
      return (sel == 4'd3) ? '0 : regs[sel];
   endfunction

   assign dataWr = wrEn && (dstSel != 4'd3);
   assign srWr   = dataWr && (dstSel == 4'd2);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < 16; i++)
            regs[i] <= '0;
         regs[0] <= `REGUNIT_RST_VEC;
      end
      else
      begin
         if (dataWr)
         begin
            // PC below the bound goes back to the reset vector
            if (dstSel == 4'd0 && wrData < `REGUNIT_PC_MIN)
               regs[0] <= `REGUNIT_RST_VEC;
            else
               regs[dstSel] <= wrData;
         end
         // Data write to R2 takes priority over flags
         if (flagWr && !srWr)
         begin
            regs[2][cpuTypes_pkg::flagC] <= flags[cpuTypes_pkg::flagC];
            regs[2][cpuTypes_pkg::flagZ] <= flags[cpuTypes_pkg::flagZ];
            regs[2][cpuTypes_pkg::flagN] <= flags[cpuTypes_pkg::flagN];
         end
      end
   end

   // Source operand with constant generators
   always_comb
   begin
      if (srcSel == 4'd2)
      begin
         case (mode)
            2'd0:    srcVal = regs[2];
            2'd1:    srcVal = 16'h0000;
            2'd2:    srcVal = 16'h0004;
            default: srcVal = 16'h0008;
         endcase
      end
      else if (srcSel == 4'd3)
      begin
         case (mode)
            2'd0:    srcVal = 16'h0000;
            2'd1:    srcVal = 16'h0001;
            2'd2:    srcVal = 16'h0002;
            default: srcVal = 16'hFFFF;
         endcase
      end
      else
         srcVal = regs[srcSel];
   end

   assign dstVal = storedVal(dstSel);
   assign rdVal  = storedVal(rdSel);

   assign pc = regs[0];
   assign sp = regs[1];
   assign sr = regs[2];

endmodule

//--- regUnit.sv
////////////////////////////////////////////////////////////
// Top level: Wishbone port, queue, executor, register file
////////////////////////////////////////////////////////////
`include "regUnit_params.svh"

module regUnit
#(
   parameter int FIFO_DEPTH = `REGUNIT_FIFO_DEPTH
)
(
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cyc,
   input  logic                 stb,
   input  logic                 we,
   input  busTypes_pkg::wbAdr   adr,
   input  busTypes_pkg::wbData  datW,
   output busTypes_pkg::wbData  datR,
   output logic                 ack,
   output logic                 idle,
   output cpuTypes_pkg::regWord pc,
   output cpuTypes_pkg::regWord sp,
   output cpuTypes_pkg::regWord sr
);

   logic push, pop, full, empty, busy, wrEn, flagWr;
   busTypes_pkg::opWord   pushData, popData;
   cpuTypes_pkg::regIdx   srcSel, dstSel, rdSel;
   cpuTypes_pkg::addrMode mode;
   cpuTypes_pkg::regWord  srcVal, dstVal, rdVal, wrData, flags;

   // Nothing queued and nothing in progress
   assign idle = empty && !busy;

   opPort port_inst (.clk, .rst, .cyc, .stb, .we, .adr, .datW, .datR, .ack,
      .full, .push, .pushData, .rdSel, .rdVal);

   opFifo #(.DEPTH(FIFO_DEPTH)) fifo_inst (.clk, .rst, .push, .pop, .pushData,
      .popData, .full, .empty);

   opExecute exec_inst (.clk, .rst, .empty, .popData, .pop, .srcSel, .dstSel,
      .mode, .srcVal, .dstVal, .wrEn, .flagWr, .wrData, .flags, .busy);

   regFile regs_inst (.clk, .rst, .srcSel, .dstSel, .rdSel, .mode, .srcVal,
      .dstVal, .rdVal, .pc, .sp, .sr, .wrEn, .flagWr, .wrData, .flags);

endmodule

//--- regUnit_props.sv
////////////////////////////////////////////////////////////
// Bound checks on the Wishbone ack and the queue handshake
////////////////////////////////////////////////////////////
module regUnit_props
(
   input logic clk,
   input logic rst,
   input logic ack,
   input logic push,
   input logic full
);

   // Ack is a single-cycle pulse
   ackPulse: assert property (@(posedge clk) disable iff (rst) ack |=> !ack)
      else $error("ack stayed high for two cycles");

   // Back-pressure keeps pushes away from a full queue
   noPushFull: assert property (@(posedge clk) disable iff (rst) !(push && full))
      else $error("push while the FIFO is full");

endmodule

// Port side sees ack, its own push and the queue full flag
bind opPort regUnit_props portChecks (.clk(clk), .rst(rst), .ack(ack), .push(push),
   .full(full));

//--- tb_regUnit.sv
////////////////////////////////////////////////////////////
// Testbench for regUnit: random operations against a model
////////////////////////////////////////////////////////////
`include "regUnit_params.svh"

module tb_regUnit;

   localparam int totalOps = 386;
   localparam int watchCycles = totalOps * 40 + 4000;
   localparam int ackLimit = 64;
   localparam int idleLimit = 400;

   logic clk;
   logic rst;
   logic cyc;
   logic stb;
   logic we;
   logic ack;
   logic idle;
   busTypes_pkg::wbAdr   adr;
   busTypes_pkg::wbData  datW;
   busTypes_pkg::wbData  datR;
   cpuTypes_pkg::regWord pc;
   cpuTypes_pkg::regWord sp;
   cpuTypes_pkg::regWord sr;

   // Expected register contents
   cpuTypes_pkg::regWord model [16];
   logic [31:0] rngState;
   int errors;
   int checks;

   regUnit regUnit_inst (.clk, .rst, .cyc, .stb, .we, .adr, .datW, .datR, .ack, .idle,
      .pc, .sp, .sr);

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // Hard stop well past the time all operations need
   initial
   begin
      repeat (watchCycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", watchCycles);
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [31:0] nextRand();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   task automatic compareWord(input cpuTypes_pkg::regWord got,
      input cpuTypes_pkg::regWord exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at time %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compareBit(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERROR at time %0t: %s was %b, expected %b", $time, what, got, exp);
      end
   endtask

   function automatic busTypes_pkg::opWord makeOp(input busTypes_pkg::opCode code,
      input cpuTypes_pkg::addrMode asMode, input cpuTypes_pkg::regIdx src,
      input cpuTypes_pkg::regIdx dst, input cpuTypes_pkg::regWord imm);
      return {code, asMode, src, dst, 4'h0, imm};
   endfunction

   // Kind 0 load or move, 1 add, otherwise any opcode
   function automatic busTypes_pkg::opWord randOp(input int kind);
      logic [31:0] r;
      logic [31:0] v;
      busTypes_pkg::opCode code;
      cpuTypes_pkg::regWord imm;
      r = nextRand();
      v = nextRand();
      case (kind)
         0:       code = r[0] ? busTypes_pkg::opMov : busTypes_pkg::opLoad;
         1:       code = busTypes_pkg::opAdd;
         default: code = busTypes_pkg::opCode'(r[1:0]);
      endcase
      // Small immediates half the time so some PC writes fall below the bound
      imm = r[2] ? v[15:0] : (v[15:0] & 16'h03FF);
      return makeOp(code, r[5:4], r[11:8], r[15:12], imm);
   endfunction

   // Reference behavior of one operation on the model
   task automatic applyOp(input busTypes_pkg::opWord op);
      logic [1:0] code;
      cpuTypes_pkg::addrMode asMode;
      cpuTypes_pkg::regIdx src;
      cpuTypes_pkg::regIdx dst;
      cpuTypes_pkg::regWord s;
      cpuTypes_pkg::regWord d;
      cpuTypes_pkg::regWord value;
      logic [16:0] sum;
      code = op[31:30];
      asMode = op[29:28];
      src = op[27:24];
      dst = op[23:20];
      s = model[src];
      // Constant generators on R2 and R3
      if (src == 4'd2 && asMode != 2'd0)
         s = (asMode == 2'd1) ? 16'h0000 : ((asMode == 2'd2) ? 16'h0004 : 16'h0008);
      if (src == 4'd3)
         s = (asMode == 2'd3) ? 16'hFFFF : cpuTypes_pkg::regWord'(asMode);
      d = (dst == 4'd3) ? 16'h0000 : model[dst];
      sum = {1'b0, s} + {1'b0, d};
      case (code)
         2'd0:    value = op[15:0];
         2'd1:    value = s;
         default: value = sum[15:0];
      endcase
      if (code != 2'd3 && dst != 4'd3)
      begin
         if (dst == 4'd0 && value < `REGUNIT_PC_MIN)
            model[0] = `REGUNIT_RST_VEC;
         else
            model[dst] = value;
      end
      if (code == 2'd2 && dst != 4'd2)
      begin
         model[2][cpuTypes_pkg::flagC] = sum[16];
         model[2][cpuTypes_pkg::flagZ] = (sum[15:0] == 16'h0000);
         model[2][cpuTypes_pkg::flagN] = sum[15];
      end
   endtask

   // Chained means the previous transfer was acknowledged on the last edge
   task automatic busWrite(input busTypes_pkg::wbAdr a, input busTypes_pkg::wbData d,
      input bit chained);
      int n;
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b1;
      adr = a;
      datW = d;
      n = 0;
      @(negedge clk);
      if (chained)
         compareBit(ack, 1'b0, "ack in the cycle after an ack");
      while (!ack && n < ackLimit)
      begin
         @(negedge clk);
         n++;
      end
      if (!ack)
      begin
         errors++;
         $display("Write to address %0d was never acknowledged", a);
      end
   endtask

   task automatic busRelease();
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      @(negedge clk);
   endtask

   task automatic busRead(input busTypes_pkg::wbAdr a, output busTypes_pkg::wbData d);
      cyc = 1'b1;
      stb = 1'b1;
      we = 1'b0;
      adr = a;
      @(negedge clk);
      compareBit(ack, 1'b1, "read ack one cycle after request");
      d = datR;
      busRelease();
   endtask

   task automatic waitIdle();
      int n;
      n = 0;
      // Let the last push reach the queue first
      repeat (2) @(negedge clk);
      while (!idle && n < idleLimit)
      begin
         @(negedge clk);
         n++;
      end
      if (!idle)
      begin
         errors++;
         $display("The unit did not return to idle after %0d cycles", idleLimit);
      end
   endtask

   task automatic checkAll(input string tag);
      busTypes_pkg::wbData d;
      for (int i = 0; i < 16; i++)
      begin
         busRead(busTypes_pkg::wbAdr'(i), d);
         compareWord(d[15:0], model[i], $sformatf("%s R%0d", tag, i));
         compareWord(d[31:16], 16'h0000, $sformatf("%s R%0d upper bits", tag, i));
      end
      compareWord(pc, model[0], {tag, " pc output"});
      compareWord(sp, model[1], {tag, " sp output"});
      compareWord(sr, model[2], {tag, " sr output"});
   endtask

   // Random operations as one burst, then wait for the queue to drain
   task automatic sendBatch(input int count, input int kind);
      busTypes_pkg::opWord op;
      for (int i = 0; i < count; i++)
      begin
         op = randOp(kind);
         applyOp(op);
         busWrite(4'd0, op, i != 0);
      end
      busRelease();
      waitIdle();
   endtask

   task automatic sendOne(input busTypes_pkg::opWord op);
      applyOp(op);
      busWrite(4'd0, op, 1'b0);
      busRelease();
   endtask

   task automatic testDone(input int num, input string name, input int errStart);
      $display("Test %0d %s finished with %0d errors", num, name, errors - errStart);
   endtask

   initial
   begin
      int errStart;
      busTypes_pkg::wbData d;
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      datW = '0;
      rngState = 32'h2b20;
      errors = 0;
      checks = 0;
      for (int i = 0; i < 16; i++)
         model[i] = '0;
      model[0] = `REGUNIT_RST_VEC;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);

      errStart = errors;
      compareBit(idle, 1'b1, "idle after reset");
      checkAll("reset");
      testDone(1, "reset values", errStart);

      errStart = errors;
      repeat (5)
      begin
         sendBatch(40, 0);
         checkAll("load/mov");
      end
      testDone(2, "load and move", errStart);

      errStart = errors;
      repeat (6)
      begin
         sendBatch(20, 1);
         checkAll("add");
      end
      testDone(3, "add with flags", errStart);

      errStart = errors;
      repeat (4)
      begin
         sendBatch(12, 2);
         checkAll("burst");
      end
      testDone(4, "write bursts", errStart);

      // R2 as destination keeps the sum, 1230 + F000 carries out
      errStart = errors;
      sendOne(makeOp(busTypes_pkg::opLoad, 2'd0, 4'd0, 4'd2, 16'h1230));
      sendOne(makeOp(busTypes_pkg::opLoad, 2'd0, 4'd0, 4'd5, 16'hF000));
      sendOne(makeOp(busTypes_pkg::opAdd, 2'd0, 4'd5, 4'd2, 16'h0000));
      waitIdle();
      busRead(4'd2, d);
      compareWord(d[15:0], 16'h0230, "R2 after add into R2");
      for (int a = 1; a < 16; a++)
      begin
         busWrite(busTypes_pkg::wbAdr'(a), nextRand(), 1'b0);
         busRelease();
         compareBit(idle, 1'b1, "idle after write to a non-zero address");
      end
      checkAll("dropped");
      testDone(5, "R2 destination and dropped writes", errStart);

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("RESULT: FAIL");
         $finish;
      end
   end

endmodule

//--- all.f
+incdir+.
cpuTypes_pkg.sv
busTypes_pkg.sv
opPort.sv
opFifo.sv
opExecute.sv
regFile.sv
regUnit.sv
regUnit_props.sv
tb_regUnit.sv

//--- run.sh
#!/bin/sh
# Build and run the regUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_regUnit -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_regUnit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
